// ==== design/rv_pkg.sv ====
package rv_pkg;

  localparam int XLEN = 32;
  localparam logic [XLEN-1:0] RESET_PC = '0;

  // Major opcodes
  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_AUIPC  = 7'b0010111;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_REG    = 7'b0110011;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
    ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
  } alu_op_e;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  // One instruction word, seen through each encoding format
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    s_fmt_t s;
    b_fmt_t b;
    u_fmt_t u;
    j_fmt_t j;
  } inst_u;

  typedef struct packed {
    logic            valid;
    logic            we;
    logic [3:0]      strb;
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] wdata;
  } mem_req_t;

  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] rdata;
  } mem_rsp_t;

  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] pc;
    inst_u           inst;
  } fetch_t;

  typedef struct packed {
    logic            done;
    logic            jump;
    logic [XLEN-1:0] target;
  } redirect_t;

  typedef struct packed {
    logic            is_load;
    logic            is_store;
    logic            is_branch;
    logic            is_jal;
    logic            is_jalr;
    logic            is_halt;
    alu_op_e         alu_op;
    logic            use_imm;
    logic            use_pc;
    logic [2:0]      funct3;
    logic [4:0]      rd;
    logic            rd_wen;
    logic [XLEN-1:0] imm;
  } dec_t;

  typedef struct packed {
    logic            valid;
    logic            we;
    logic [2:0]      funct3;
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] wdata;
  } ls_req_t;

  typedef struct packed {
    logic            en;
    logic [4:0]      addr;
    logic [XLEN-1:0] data;
  } gpr_wr_t;

endpackage

// ==== design/gpr_file.sv ====
module gpr_file import rv_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  input  logic [4:0]      raddr1,
  input  logic [4:0]      raddr2,
  output logic [XLEN-1:0] rdata1,
  output logic [XLEN-1:0] rdata2,
  input  gpr_wr_t         wr
);

  // x0 has no storage
  logic [XLEN-1:0] regs [1:31];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr.en && wr.addr != 5'd0) begin
      regs[wr.addr] <= wr.data;
    end
  end

  assign rdata1 = (raddr1 == 5'd0) ? '0 : regs[raddr1];
  assign rdata2 = (raddr2 == 5'd0) ? '0 : regs[raddr2];

endmodule

// ==== design/fetch_unit.sv ====
module fetch_unit import rv_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  output fetch_t    inst_out,
  input  redirect_t redirect,
  input  logic      halted,
  output mem_req_t  bus_req,
  input  mem_rsp_t  bus_rsp
);

  logic [XLEN-1:0] pc;
  logic [XLEN-1:0] req_addr;
  logic [XLEN-1:0] pf_inst;
  inst_u           cur_inst;
  logic            cur_valid;
  logic            pf_valid;
  logic            busy;
  logic            discard;
  logic            rsp_take;
  logic            advance;
  logic            jump;
  logic            issue;

  assign rsp_take = busy && bus_rsp.valid && !discard;
  assign advance  = redirect.done && !redirect.jump;
  assign jump     = redirect.done && redirect.jump;
  // Read pc while cur is empty and pc+4 once it is held
  assign issue = !busy && !halted && (!cur_valid || !pf_valid);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc        <= RESET_PC;
      cur_valid <= 1'b0;
      pf_valid  <= 1'b0;
      busy      <= 1'b0;
      discard   <= 1'b0;
    end else begin
      if (jump) begin
        pc        <= redirect.target;
        cur_valid <= 1'b0;
        pf_valid  <= 1'b0;
        discard   <= issue || (busy && !bus_rsp.valid);
      end else if (advance) begin
        pc        <= pc + 32'd4;
        cur_valid <= pf_valid || rsp_take;
        pf_valid  <= 1'b0;
      end else begin
        if (rsp_take && !cur_valid) cur_valid <= 1'b1;
        if (rsp_take && cur_valid) pf_valid <= 1'b1;
        if (busy && bus_rsp.valid) discard <= 1'b0;
      end
      if (issue) busy <= 1'b1;
      else if (bus_rsp.valid) busy <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (advance && pf_valid) cur_inst <= pf_inst;
    else if (rsp_take && (advance || !cur_valid)) cur_inst <= bus_rsp.rdata;
    if (rsp_take && cur_valid && !redirect.done) pf_inst <= bus_rsp.rdata;
    if (issue) req_addr <= cur_valid ? pc + 32'd4 : pc;
  end

  assign inst_out.valid = cur_valid;
  assign inst_out.pc    = pc;
  assign inst_out.inst  = cur_inst;

  assign bus_req.valid = busy;
  assign bus_req.we    = 1'b0;
  assign bus_req.strb  = 4'hf;
  assign bus_req.addr  = req_addr;
  assign bus_req.wdata = '0;

endmodule

// ==== design/decoder.sv ====
module decoder import rv_pkg::*; (
  input  inst_u      inst,
  output dec_t       dec,
  output logic [4:0] rs1,
  output logic [4:0] rs2
);

  logic [XLEN-1:0] i_imm;
  logic [XLEN-1:0] s_imm;
  logic [XLEN-1:0] b_imm;
  logic [XLEN-1:0] u_imm;
  logic [XLEN-1:0] j_imm;
  logic            imm_alt;

  function automatic alu_op_e alu_sel(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  alu_sel = alt ? ALU_SUB : ALU_ADD;
      3'b001:  alu_sel = ALU_SLL;
      3'b010:  alu_sel = ALU_SLT;
      3'b011:  alu_sel = ALU_SLTU;
      3'b100:  alu_sel = ALU_XOR;
      3'b101:  alu_sel = alt ? ALU_SRA : ALU_SRL;
      3'b110:  alu_sel = ALU_OR;
      default: alu_sel = ALU_AND;
    endcase
  endfunction

  assign i_imm = {{20{inst.i.imm[11]}}, inst.i.imm};
  assign s_imm = {{20{inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};
  assign b_imm = {{19{inst.b.imm12}}, inst.b.imm12, inst.b.imm11,
                  inst.b.imm10_5, inst.b.imm4_1, 1'b0};
  assign u_imm = {inst.u.imm, 12'b0};
  assign j_imm = {{11{inst.j.imm20}}, inst.j.imm20, inst.j.imm19_12,
                  inst.j.imm11, inst.j.imm10_1, 1'b0};

  // No SUBI, only SRAI uses bit 30
  assign imm_alt = inst.r.funct7[5] && inst.r.funct3 == 3'b101;

  always_comb begin
    dec        = '0;
    dec.alu_op = ALU_ADD;
    dec.funct3 = inst.r.funct3;
    dec.rd     = inst.r.rd;
    rs1        = inst.r.rs1;
    rs2        = inst.r.rs2;
    case (inst.r.opcode)
      OP_LUI: begin
        rs1         = 5'd0;
        dec.rd_wen  = 1'b1;
        dec.use_imm = 1'b1;
        dec.imm     = u_imm;
      end
      OP_AUIPC: begin
        dec.rd_wen  = 1'b1;
        dec.use_imm = 1'b1;
        dec.use_pc  = 1'b1;
        dec.imm     = u_imm;
      end
      OP_JAL: begin
        dec.is_jal = 1'b1;
        dec.rd_wen = 1'b1;
        dec.imm    = j_imm;
      end
      OP_JALR: begin
        dec.is_jalr = 1'b1;
        dec.rd_wen  = 1'b1;
        dec.use_imm = 1'b1;
        dec.imm     = i_imm;
      end
      OP_BRANCH: begin
        dec.is_branch = 1'b1;
        dec.imm       = b_imm;
      end
      OP_LOAD: begin
        dec.is_load = 1'b1;
        dec.rd_wen  = 1'b1;
        dec.use_imm = 1'b1;
        dec.imm     = i_imm;
      end
      OP_STORE: begin
        dec.is_store = 1'b1;
        dec.use_imm  = 1'b1;
        dec.imm      = s_imm;
      end
      OP_IMM: begin
        dec.rd_wen  = 1'b1;
        dec.use_imm = 1'b1;
        dec.imm     = i_imm;
        dec.alu_op  = alu_sel(inst.i.funct3, imm_alt);
      end
      OP_REG: begin
        dec.rd_wen = 1'b1;
        dec.alu_op = alu_sel(inst.r.funct3, inst.r.funct7[5]);
      end
      // EBREAK and the rest of the system group stop the core
      OP_SYSTEM: dec.is_halt = 1'b1;
      default:   dec.is_halt = 1'b1;
    endcase
    if (dec.rd == 5'd0) dec.rd_wen = 1'b0;
  end

endmodule

// ==== design/exec_unit.sv ====
module exec_unit import rv_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  input  fetch_t          inst_in,
  input  dec_t            dec,
  input  logic [XLEN-1:0] rdata1,
  input  logic [XLEN-1:0] rdata2,
  output redirect_t       redirect,
  output gpr_wr_t         gpr_wr,
  output ls_req_t         ls_req,
  input  logic            ls_done,
  input  logic [XLEN-1:0] ls_rdata,
  output logic            halted
);

  typedef enum logic {S_ISSUE, S_WAIT} state_e;

  state_e          state;
  logic            halt_q;
  logic            mem_op;
  logic            taken;
  logic [XLEN-1:0] op_a;
  logic [XLEN-1:0] op_b;
  logic [XLEN-1:0] alu_res;
  logic [XLEN-1:0] pc_plus4;

  assign mem_op   = inst_in.valid && (dec.is_load || dec.is_store);
  assign op_a     = dec.use_pc ? inst_in.pc : rdata1;
  assign op_b     = dec.use_imm ? dec.imm : rdata2;
  assign pc_plus4 = inst_in.pc + 32'd4;

  always_comb begin
    case (dec.alu_op)
      ALU_ADD:  alu_res = op_a + op_b;
      ALU_SUB:  alu_res = op_a - op_b;
      ALU_SLL:  alu_res = op_a << op_b[4:0];
      ALU_SLT:  alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
      ALU_SLTU: alu_res = {31'b0, op_a < op_b};
      ALU_XOR:  alu_res = op_a ^ op_b;
      ALU_SRL:  alu_res = op_a >> op_b[4:0];
      ALU_SRA:  alu_res = $signed(op_a) >>> op_b[4:0];
      ALU_OR:   alu_res = op_a | op_b;
      default:  alu_res = op_a & op_b;
    endcase
  end

  always_comb begin
    case (dec.funct3)
      3'b000:  taken = rdata1 == rdata2;
      3'b001:  taken = rdata1 != rdata2;
      3'b100:  taken = $signed(rdata1) < $signed(rdata2);
      3'b101:  taken = $signed(rdata1) >= $signed(rdata2);
      3'b110:  taken = rdata1 < rdata2;
      default: taken = rdata1 >= rdata2;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state  <= S_ISSUE;
      halt_q <= 1'b0;
    end else begin
      if (state == S_ISSUE && mem_op) state <= S_WAIT;
      else if (state == S_WAIT && ls_done) state <= S_ISSUE;
      if (inst_in.valid && dec.is_halt) halt_q <= 1'b1;
    end
  end

  // Memory ops finish on ls_done, everything else on first sight
  assign redirect.done = (state == S_WAIT) ? ls_done
                                           : inst_in.valid && !mem_op && !dec.is_halt;
  assign redirect.jump   = dec.is_jal || dec.is_jalr || (dec.is_branch && taken);
  assign redirect.target = dec.is_jalr ? {alu_res[XLEN-1:1], 1'b0} : inst_in.pc + dec.imm;

  assign gpr_wr.en   = redirect.done && dec.rd_wen;
  assign gpr_wr.addr = dec.rd;
  assign gpr_wr.data = dec.is_load ? ls_rdata :
                       (dec.is_jal || dec.is_jalr) ? pc_plus4 : alu_res;

  assign ls_req.valid  = mem_op;
  assign ls_req.we     = dec.is_store;
  assign ls_req.funct3 = dec.funct3;
  assign ls_req.addr   = alu_res;
  assign ls_req.wdata  = rdata2;

  assign halted = halt_q || (inst_in.valid && dec.is_halt);

endmodule

// ==== design/lsu.sv ====
module lsu import rv_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  input  ls_req_t         req,
  output logic            done,
  output logic [XLEN-1:0] rdata,
  output mem_req_t        bus_req,
  input  mem_rsp_t        bus_rsp
);

  logic [1:0]      off;
  logic [XLEN-1:0] lane;
  logic            pending;

  assign off = req.addr[1:0];

  assign bus_req.valid = req.valid;
  assign bus_req.we    = req.we;
  assign bus_req.addr  = {req.addr[XLEN-1:2], 2'b00};
  assign bus_req.wdata = req.wdata << {off, 3'b000};

  always_comb begin
    case (req.funct3[1:0])
      2'b00:   bus_req.strb = 4'b0001 << off;
      2'b01:   bus_req.strb = 4'b0011 << off;
      default: bus_req.strb = 4'b1111;
    endcase
  end

  // Set once issued, so a stray response is not taken as completion
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) pending <= 1'b0;
    else if (bus_rsp.valid) pending <= 1'b0;
    else if (bus_req.valid) pending <= 1'b1;
  end

  assign done = pending && bus_rsp.valid;

  assign lane = bus_rsp.rdata >> {off, 3'b000};

  always_comb begin
    case (req.funct3)
      3'b000:  rdata = {{24{lane[7]}}, lane[7:0]};
      3'b001:  rdata = {{16{lane[15]}}, lane[15:0]};
      3'b100:  rdata = {24'b0, lane[7:0]};
      3'b101:  rdata = {16'b0, lane[15:0]};
      default: rdata = lane;
    endcase
  end

endmodule

// ==== design/bus_arbiter.sv ====
module bus_arbiter import rv_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  mem_req_t ifu_req,
  output mem_rsp_t ifu_rsp,
  input  mem_req_t lsu_req,
  output mem_rsp_t lsu_rsp,
  output mem_req_t mem_req,
  input  mem_rsp_t mem_rsp
);

  logic busy;
  logic owner_lsu;
  logic grant_lsu;

  // LSU wins when idle, otherwise the owner keeps the bus
  assign grant_lsu = busy ? owner_lsu : lsu_req.valid;
  assign mem_req   = grant_lsu ? lsu_req : ifu_req;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy      <= 1'b0;
      owner_lsu <= 1'b0;
    end else if (!busy) begin
      if (mem_req.valid) begin
        busy      <= 1'b1;
        owner_lsu <= grant_lsu;
      end
    end else if (mem_rsp.valid) begin
      busy <= 1'b0;
    end
  end

  assign lsu_rsp.valid = mem_rsp.valid && grant_lsu;
  assign lsu_rsp.rdata = mem_rsp.rdata;
  assign ifu_rsp.valid = mem_rsp.valid && !grant_lsu;
  assign ifu_rsp.rdata = mem_rsp.rdata;

endmodule

// ==== design/rv_core.sv ====
module rv_core import rv_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  output mem_req_t mem_req,
  input  mem_rsp_t mem_rsp,
  output logic     halted
);

  fetch_t          fetched;
  redirect_t       redirect;
  dec_t            dec;
  gpr_wr_t         gpr_wr;
  ls_req_t         ls_req;
  logic [4:0]      rs1;
  logic [4:0]      rs2;
  logic [XLEN-1:0] rdata1;
  logic [XLEN-1:0] rdata2;
  logic [XLEN-1:0] ls_rdata;
  logic            ls_done;
  mem_req_t        ifu_req;
  mem_rsp_t        ifu_rsp;
  mem_req_t        lsu_req;
  mem_rsp_t        lsu_rsp;

  fetch_unit u_fetch (
    .clk(clk), .rst_n(rst_n),
    .inst_out(fetched), .redirect(redirect), .halted(halted),
    .bus_req(ifu_req), .bus_rsp(ifu_rsp)
  );

  decoder u_dec (.inst(fetched.inst), .dec(dec), .rs1(rs1), .rs2(rs2));

  gpr_file u_gpr (
    .clk(clk), .rst_n(rst_n),
    .raddr1(rs1), .raddr2(rs2), .rdata1(rdata1), .rdata2(rdata2),
    .wr(gpr_wr)
  );

  exec_unit u_exec (
    .clk(clk), .rst_n(rst_n),
    .inst_in(fetched), .dec(dec), .rdata1(rdata1), .rdata2(rdata2),
    .redirect(redirect), .gpr_wr(gpr_wr),
    .ls_req(ls_req), .ls_done(ls_done), .ls_rdata(ls_rdata),
    .halted(halted)
  );

  lsu u_lsu (
    .clk(clk), .rst_n(rst_n),
    .req(ls_req), .done(ls_done), .rdata(ls_rdata),
    .bus_req(lsu_req), .bus_rsp(lsu_rsp)
  );

  bus_arbiter u_arb (
    .clk(clk), .rst_n(rst_n),
    .ifu_req(ifu_req), .ifu_rsp(ifu_rsp),
    .lsu_req(lsu_req), .lsu_rsp(lsu_rsp),
    .mem_req(mem_req), .mem_rsp(mem_rsp)
  );

endmodule

// ==== tb/tb_mem.sv ====
module tb_mem import rv_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     ws_en,
  input  mem_req_t req,
  output mem_rsp_t rsp,
  output logic     stable_err
);

  logic [31:0] mem [0:1023];
  mem_req_t    req_s;
  mem_req_t    held;
  logic        busy;
  int          wait_cnt;
  integer      seed = 32'h035c_0b1e;

  initial begin
    rsp        = '0;
    stable_err = 1'b0;
  end

  // Sampled mid-cycle, so this is what the next rising edge sees
  always @(negedge clk) req_s <= req;

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy <= 1'b0;
      rsp  <= '0;
    end else begin
      if (busy) begin
        assert (req_s == held) else stable_err <= 1'b1;
      end
      if (rsp.valid) begin
        busy <= 1'b0;
        rsp  <= #1 '0;
      end else if (busy && wait_cnt > 0) begin
        wait_cnt <= wait_cnt - 1;
      end else if (busy) begin
        if (held.we) begin
          for (int b = 0; b < 4; b++) begin
            if (held.strb[b]) mem[held.addr[11:2]][8*b +: 8] = held.wdata[8*b +: 8];
          end
          rsp <= #1 {1'b1, 32'h0};
        end else begin
          rsp <= #1 {1'b1, mem[held.addr[11:2]]};
        end
      end else if (req_s.valid) begin
        held     <= req_s;
        busy     <= 1'b1;
        wait_cnt <= ws_en ? ($random(seed) & 3) : 0;
      end
    end
  end

endmodule

// ==== tb/tb_rv_core.sv ====
module tb_rv_core import rv_pkg::*;;

  logic        clk = 1'b0;
  logic        rst_n;
  logic        ws_en;
  logic        halted;
  logic        stable_err;
  mem_req_t    mem_req;
  mem_rsp_t    mem_rsp;
  int          pc_w;
  int          slot;
  int unsigned test_count = 6;
  int unsigned chk_addr [$];
  logic [31:0] chk_val [$];

  localparam int RES  = 32'h700;
  localparam int SENT = 32'h6f0;

  always #20 clk = ~clk;

  rv_core DUT (
    .clk(clk), .rst_n(rst_n),
    .mem_req(mem_req), .mem_rsp(mem_rsp), .halted(halted)
  );

  tb_mem u_mem (
    .clk(clk), .rst_n(rst_n), .ws_en(ws_en),
    .req(mem_req), .rsp(mem_rsp), .stable_err(stable_err)
  );

  task automatic stop_run(input string line);
    $display("%s", line);
    $display("Done: errors found");
    $fatal(1, "Simulation stopped after a failure");
  endtask

  // RV32I encoders
  function automatic logic [31:0] enc_r(input int f7, rs2, rs1, f3, rd);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
  endfunction

  function automatic logic [31:0] enc_i(input int imm, rs1, f3, rd, op);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
  endfunction

  function automatic logic [31:0] enc_s(input int imm, rs2, rs1, f3);
    return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], 7'h23};
  endfunction

  function automatic logic [31:0] enc_b(input int imm, rs1, rs2, f3);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic logic [31:0] enc_u(input int imm, rd, op);
    return {imm[19:0], rd[4:0], op[6:0]};
  endfunction

  function automatic logic [31:0] enc_j(input int imm, rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6f};
  endfunction

  task automatic put(input logic [31:0] w);
    u_mem.mem[pc_w] = w;
    pc_w++;
  endtask

  task automatic expect_word(input int unsigned addr, input logic [31:0] val);
    chk_addr.push_back(addr);
    chk_val.push_back(val);
  endtask

  // Store a register into the next result slot
  task automatic result(input int r, input logic [31:0] val);
    put(enc_s(RES + 4 * slot, r, 0, 2));
    expect_word(RES + 4 * slot, val);
    slot++;
  endtask

  task automatic start_program();
    for (int i = 0; i < 1024; i++) begin
      u_mem.mem[i] = i * 32'h9e37_79b1 ^ 32'h5a5a_5a5a;
    end
    pc_w = 0;
    slot = 0;
    chk_addr.delete();
    chk_val.delete();
  endtask

  task automatic run_program();
    int n;
    put(32'h0010_0073);
    @(posedge clk);
    #2 rst_n = 1'b0;
    repeat (4) @(posedge clk);
    #2 rst_n = 1'b1;
    n = 0;
    while (!halted) begin
      @(negedge clk);
      n++;
      if (n > 1500) stop_run("Timeout: core did not raise halted");
    end
    n = 0;
    while (mem_req.valid) begin
      @(negedge clk);
      n++;
      if (n > 20) stop_run("Timeout: in-flight request never completed after halt");
    end
    repeat (40) begin
      @(negedge clk);
      assert (halted && !mem_req.valid) else
        stop_run($sformatf("FAILED at %0t: bus request or halted change after EBREAK", $time));
    end
  endtask

  task automatic check_results();
    logic [31:0] got;
    foreach (chk_addr[k]) begin
      got = u_mem.mem[chk_addr[k] >> 2];
      assert (got === chk_val[k]) else
        stop_run($sformatf("FAILED at %0t: word at 0x%03h is 0x%08h, expected 0x%08h",
                           $time, chk_addr[k], got, chk_val[k]));
    end
  endtask

  task automatic test_alu();
    int          regs [21] = '{3, 4, 5, 6, 7, 8, 9, 10, 12, 13, 14, 15, 16, 17, 18, 19,
                               20, 21, 22, 23, 0};
    logic [31:0] vals [21] = '{32'h1, 32'h0, 32'hffffffff, 32'hfffffffb, 32'hffffffff,
                               32'h1, 32'h80000000, 32'hffffffff, 32'h1, 32'h80000000,
                               32'hfffff804, 32'hf0, 32'h555, 32'hfffffffe, 32'hffffffff,
                               32'h5f5, 32'h7ffffffb, 32'h1, 32'h1, 32'h0, 32'h0};
    int          p;
    start_program();
    put(enc_u(32'h80000, 1, 7'h37));
    put(enc_i(-1, 1, 0, 2, 7'h13));
    put(enc_r(0, 2, 1, 2, 3));
    put(enc_r(0, 2, 1, 3, 4));
    put(enc_r(32, 1, 2, 0, 5));
    put(enc_i(-5, 0, 0, 6, 7'h13));
    put(enc_i(12'h41f, 1, 5, 7, 7'h13));
    put(enc_i(31, 1, 5, 8, 7'h13));
    put(enc_i(31, 6, 1, 9, 7'h13));
    put(enc_i(31, 0, 0, 11, 7'h13));
    put(enc_r(32, 11, 6, 5, 10));
    put(enc_r(0, 11, 1, 5, 12));
    put(enc_r(0, 11, 6, 1, 13));
    put(enc_i(12'h7ff, 6, 4, 14, 7'h13));
    put(enc_i(12'h0f0, 6, 7, 15, 7'h13));
    put(enc_i(12'h555, 0, 6, 16, 7'h13));
    put(enc_r(0, 2, 2, 0, 17));
    put(enc_r(0, 2, 1, 4, 18));
    put(enc_r(0, 15, 16, 6, 19));
    put(enc_r(0, 2, 6, 7, 20));
    put(enc_i(-4, 6, 2, 21, 7'h13));
    put(enc_i(-4, 6, 3, 22, 7'h13));
    put(enc_i(5, 6, 3, 23, 7'h13));
    p = pc_w * 4;
    put(enc_u(32'h12345, 24, 7'h17));
    // Write to x0 must be dropped
    put(enc_i(5, 0, 0, 0, 7'h13));
    foreach (regs[k]) result(regs[k], vals[k]);
    result(24, p + 32'h1234_5000);
    run_program();
    check_results();
  endtask

  task automatic test_load_store();
    int          f3s  [13] = '{0, 0, 0, 0, 4, 4, 4, 4, 1, 1, 5, 5, 2};
    int          offs [13] = '{0, 1, 2, 3, 0, 1, 2, 3, 0, 2, 0, 2, 0};
    logic [31:0] vals [13] = '{32'h1, 32'hfffffff5, 32'h7f, 32'hffffff8c, 32'h1, 32'hf5,
                               32'h7f, 32'h8c, 32'hfffff501, 32'hffff8c7f, 32'hf501,
                               32'h8c7f, 32'h8c7ff501};
    start_program();
    u_mem.mem[32'h600 >> 2] = 32'h8c7f_f501;
    u_mem.mem[32'h610 >> 2] = 32'h1122_3344;
    u_mem.mem[32'h614 >> 2] = 32'h5566_7788;
    u_mem.mem[32'h618 >> 2] = 32'h0;
    u_mem.mem[32'h61c >> 2] = 32'h99aa_bbcc;
    foreach (f3s[k]) begin
      put(enc_i(32'h600 + offs[k], 0, f3s[k], 5, 7'h03));
      result(5, vals[k]);
    end
    // x6 = 0xfedcba98
    put(enc_u(32'hfedcc, 6, 7'h37));
    put(enc_i(-1384, 6, 0, 6, 7'h13));
    put(enc_s(32'h611, 6, 0, 0));
    put(enc_s(32'h616, 6, 0, 1));
    put(enc_s(32'h618, 6, 0, 2));
    put(enc_s(32'h61f, 6, 0, 0));
    put(enc_i(32'h616, 0, 5, 7, 7'h03));
    result(7, 32'h0000_ba98);
    expect_word(32'h600, 32'h8c7f_f501);
    expect_word(32'h610, 32'h1122_9844);
    expect_word(32'h614, 32'hba98_7788);
    expect_word(32'h618, 32'hfedc_ba98);
    expect_word(32'h61c, 32'h98aa_bbcc);
    run_program();
    check_results();
  endtask

  task automatic test_branch_jump();
    // x1 = -1, x2 = 1
    int f3s  [6] = '{0, 1, 4, 5, 6, 7};
    int tk_a [6] = '{1, 1, 1, 2, 2, 1};
    int tk_b [6] = '{1, 2, 2, 1, 1, 2};
    int nt_a [6] = '{1, 1, 2, 1, 1, 2};
    int nt_b [6] = '{2, 1, 1, 2, 2, 1};
    int p;
    int q;
    start_program();
    u_mem.mem[SENT >> 2] = 32'h0;
    put(enc_i(-1, 0, 0, 1, 7'h13));
    put(enc_i(1, 0, 0, 2, 7'h13));
    put(enc_i(12'h7ad, 0, 0, 3, 7'h13));
    put(enc_i(0, 0, 0, 4, 7'h13));
    foreach (f3s[k]) begin
      put(enc_b(8, tk_a[k], tk_b[k], f3s[k]));
      put(enc_s(SENT, 3, 0, 2));
      put(enc_b(8, nt_a[k], nt_b[k], f3s[k]));
      put(enc_i(1, 4, 0, 4, 7'h13));
    end
    p = pc_w * 4;
    put(enc_j(8, 5));
    put(enc_s(SENT, 3, 0, 2));
    q = pc_w * 4;
    put(enc_u(0, 6, 7'h17));
    // Odd offset, low target bit is cleared
    put(enc_i(17, 6, 0, 7, 7'h67));
    put(enc_s(SENT, 3, 0, 2));
    put(enc_s(SENT, 3, 0, 2));
    result(4, 32'd6);
    result(5, p + 4);
    result(7, q + 8);
    expect_word(SENT, 32'h0);
    run_program();
    check_results();
  endtask

  always @(posedge stable_err) begin
    stop_run("Bus request changed while waiting for its response");
  end

  initial begin
    repeat (test_count * 2000) @(posedge clk);
    stop_run("Timeout: tests did not finish in time");
  end

  initial begin
    rst_n = 1'b0;
    ws_en = 1'b0;
    test_alu();
    test_load_store();
    test_branch_jump();
    ws_en = 1'b1;
    test_alu();
    test_load_store();
    test_branch_jump();
    $display("Done: no errors");
    $finish;
  end

endmodule

// ==== tb.f ====
design/rv_pkg.sv
design/gpr_file.sv
design/fetch_unit.sv
design/decoder.sv
design/exec_unit.sv
design/lsu.sv
design/bus_arbiter.sv
design/rv_core.sv
tb/tb_mem.sv
tb/tb_rv_core.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_rv_core -o sim_rv_core
./obj_dir/sim_rv_core 2>&1 | tee sim.log
if grep -q "Done: errors found" sim.log; then
  exit 1
fi
